//--- Makefile
SRCS := $(wildcard verilog/*.sv dv/*.sv)

.PHONY: run clean

run: obj_dir/VdivSqrtTb
	./obj_dir/VdivSqrtTb

obj_dir/VdivSqrtTb: divsqrt.f $(SRCS)
	verilator --binary --timing --top-module divSqrtTb -f divsqrt.f -o VdivSqrtTb

clean:
	rm -rf obj_dir

//--- divsqrt.f
verilog/divSqrtPkg.sv
verilog/divSqrtPreproc.sv
verilog/divSqrtCycles.sv
verilog/divSqrtIter.sv
verilog/divSqrtFsm.sv
verilog/divSqrtUnit.sv
dv/divSqrtTb.sv

//--- dv/divSqrtTb.sv
// Random-stimulus testbench for the divide / square-root unit against a reference model
`default_nettype none

module divSqrtTb
  import divSqrtPkg::*;
();

  localparam int WIDTH     = 16;
  localparam int DIVCOPIES = 2;
  localparam int PERIOD    = 40;
  localparam int DRIVEDLY  = 2;
  localparam int RANDOPS   = 200;
  localparam int NUMOPS    = RANDOPS + 6;
  // Longest op is idle, load, WIDTH/2 steps, hold and release
  localparam int TIMEOUT   = (NUMOPS + 2) * (WIDTH / 2 + 8) * PERIOD;

  logic             clk;
  logic             rstN;
  logic             req;
  divSqrtOpE        op;
  logic [WIDTH-1:0] a;
  logic [WIDTH-1:0] b;
  logic             ack;
  logic [WIDTH-1:0] result;
  logic [WIDTH-1:0] rem;
  logic [15:0]      lfsrState;

  divSqrtUnit #(.WIDTH(WIDTH), .DIVCOPIES(DIVCOPIES)) UUT (
    .clk(clk), .rstN(rstN), .req(req), .op(op), .a(a), .b(b),
    .ack(ack), .result(result), .rem(rem)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Timeout: the unit stopped answering requests");
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic        bitOut;
    v = '0;
    for (int i = 0; i < n; i++) begin
      bitOut    = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (bitOut) lfsrState = lfsrState ^ 16'hB400;
      v = {v[30:0], bitOut};
    end
    return v;
  endfunction

  function automatic int lzCount(input logic [WIDTH-1:0] x);
    int n;
    n = 0;
    while (n < WIDTH && !x[WIDTH-1-n]) n++;
    return n;
  endfunction

  // Largest r with r*r <= x
  function automatic int isqrt(input int x);
    int r;
    r = 0;
    while ((r + 1) * (r + 1) <= x) r++;
    return r;
  endfunction

  // Result bits per the operation, then whole cycles of DIVCOPIES digits
  function automatic int modelCycles(input divSqrtOpE o, input logic [WIDTH-1:0] x,
                                     input logic [WIDTH-1:0] y);
    int bits;
    if (o == opSqrt) bits = (WIDTH - lzCount(x) + 1) / 2;
    else if (y == '0) bits = 1;
    else bits = lzCount(y) - lzCount(x) + 1;
    if (bits < 1) bits = 1;
    return (bits + DIVCOPIES - 1) / DIVCOPIES;
  endfunction

  task automatic checkEq(input int got, input int expected, input string what);
    if (got != expected) begin
      $display("[ERROR] %0t: %s, got %0d expected %0d", $time, what, got, expected);
      $display("Errors found");
      $fatal(1, "check failed");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One full four-phase transaction
  //////////////////////////////////////////////////////////////////////

  task automatic runOp(input divSqrtOpE o, input logic [WIDTH-1:0] x,
                       input logic [WIDTH-1:0] y);
    int expRes;
    int expRem;
    int edges;
    int hold;
    if (o == opSqrt) begin
      expRes = isqrt(int'(x));
      expRem = int'(x) - expRes * expRes;
    end else if (y == '0) begin
      expRes = (1 << WIDTH) - 1;
      expRem = int'(x);
    end else begin
      expRes = int'(x) / int'(y);
      expRem = int'(x) % int'(y);
    end
    @(posedge clk);
    #(DRIVEDLY);
    op  = o;
    a   = x;
    b   = y;
    req = 1'b1;
    // First edge after req is the load edge, counted as edge 1
    edges = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (!ack);
    checkEq(edges, modelCycles(o, x, y) + 1, "edges from load to ack");
    checkEq(int'(result), expRes, "result");
    checkEq(int'(rem), expRem, "remainder");
    // Requester lingers, outputs must not move
    hold = int'(randBits(2));
    repeat (hold) begin
      @(posedge clk);
      #1;
      checkEq(int'(ack), 1, "ack dropped while req held");
      checkEq(int'(result), expRes, "result changed while req held");
      checkEq(int'(rem), expRem, "remainder changed while req held");
    end
    #(DRIVEDLY - 1);
    req = 1'b0;
    #1;
    checkEq(int'(ack), 1, "ack fell before the next edge");
    @(posedge clk);
    #1;
    checkEq(int'(ack), 0, "ack still high one edge after req fell");
  endtask

  initial begin
    divSqrtOpE        o;
    logic [WIDTH-1:0] x;
    logic [WIDTH-1:0] y;
    lfsrState = 16'd8124;
    rstN      = 1'b0;
    req       = 1'b0;
    op        = opDiv;
    a         = '0;
    b         = '0;
    repeat (4) @(posedge clk);
    #(DRIVEDLY);
    rstN = 1'b1;
    // Idle unit never acknowledges on its own
    repeat (3) begin
      @(posedge clk);
      #1;
      checkEq(int'(ack), 0, "ack high with no request");
    end
    // Corners: zero and all-ones radicand, zero divisor, small dividend
    runOp(opSqrt, '0, '0);
    runOp(opSqrt, '1, 16'h5A5A);
    runOp(opDiv, 16'h1234, '0);
    runOp(opDiv, '0, '0);
    runOp(opDiv, 16'h0005, 16'h0F00);
    runOp(opDiv, '1, 16'h0001);
    // Shifted operands spread the leading-zero counts
    for (int i = 0; i < RANDOPS; i++) begin
      o = (randBits(1) == 32'd1) ? opSqrt : opDiv;
      x = WIDTH'(randBits(WIDTH)) >> randBits(4);
      y = WIDTH'(randBits(WIDTH)) >> randBits(4);
      runOp(o, x, y);
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/divSqrtCycles.sv
// Iteration-cycle count from the number of result bits to be produced
`default_nettype none

module divSqrtCycles #(
  parameter int WIDTH     = 16,
  parameter int DIVCOPIES = 2
) (
  input  logic [$clog2(WIDTH+1)-1:0] resultBits,
  output logic [$clog2(WIDTH+1)-1:0] cycles
);

  localparam int CNTW = $clog2(WIDTH+1);

  // Digits retired per cycle, sized to the count
  localparam logic [CNTW-1:0] COPIES = CNTW'(DIVCOPIES);

  //////////////////////////////////////////////////////////////////////
  // Cycle count
  //////////////////////////////////////////////////////////////////////

  // The datapath chains DIVCOPIES restoring stages per clock, so
  // cycles = ceil(resultBits / DIVCOPIES)
  // Written as (n-1)/k + 1 which is exact for n >= 1
  // Preproc never hands over zero result bits
  // Division by a constant, so it folds away in synthesis
  // For DIVCOPIES a power of two it becomes a plain shift

  always_comb begin
    cycles = (resultBits - 1'b1) / COPIES + 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/divSqrtFsm.sv
// Four-phase req/ack control FSM with the iteration down-counter
`default_nettype none

module divSqrtFsm import divSqrtPkg::*; #(
  parameter int WIDTH     = 16,
  parameter int DIVCOPIES = 2
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       req,
  input  logic [$clog2(WIDTH+1)-1:0] cycles,
  output logic                       ack,
  output logic                       load,
  output logic                       step
);

  localparam int CNTW = $clog2(WIDTH+1);

  divSqrtStateE    stateQ;
  divSqrtStateE    stateD;
  logic [CNTW-1:0] cntQ;
  // Last busy cycle of the iteration
  logic            lastStep;

  assign lastStep = (cntQ == CNTW'(1));

  //////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    stateD = stateQ;
    load   = 1'b0;
    step   = 1'b0;
    ack    = 1'b0;
    case (stateQ)
      stIdle: begin
        if (req) begin
          load   = 1'b1;
          stateD = stBusy;
        end
      end
      stBusy: begin
        step = 1'b1;
        if (lastStep) stateD = stDone;
      end
      stDone: begin
        // Results held until the requester lets go
        ack = 1'b1;
        if (!req) stateD = stIdle;
      end
      default: stateD = stIdle;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State and counter registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stateQ <= stIdle;
      cntQ   <= '0;
    end else begin
      stateQ <= stateD;
      if (load)      cntQ <= cycles;
      else if (step) cntQ <= cntQ - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/divSqrtIter.sv
// Restoring digit-recurrence datapath with DIVCOPIES chained stages per cycle
`default_nettype none

module divSqrtIter import divSqrtPkg::*; #(
  parameter int WIDTH     = 16,
  parameter int DIVCOPIES = 2
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       load,
  input  logic                       step,
  input  divSqrtOpE                  op,
  input  logic [WIDTH-1:0]           a,
  input  logic [WIDTH-1:0]           b,
  input  logic [$clog2(WIDTH+1)-1:0] cycles,
  input  logic                       divByZero,
  output logic [WIDTH-1:0]           result,
  output logic [WIDTH-1:0]           rem
);

  // Shift width covers 0..WIDTH
  localparam int SHW = $clog2(2*WIDTH+1);

  // Latched operation and flag
  divSqrtOpE          opQ;
  logic               dbzQ;
  // Payload registers
  logic [WIDTH-1:0]   bQ;
  logic [WIDTH+1:0]   remQ;
  logic [WIDTH-1:0]   opndQ;
  logic [WIDTH-1:0]   resultQ;

  logic [SHW-1:0]     digits;
  logic [SHW-1:0]     opBits;
  logic [SHW-1:0]     shiftAmt;
  logic [2*WIDTH-1:0] preShift;

  // Stage chain, index 0 is the register contents
  logic [WIDTH+1:0]   prStage   [0:DIVCOPIES];
  logic [WIDTH-1:0]   opndStage [0:DIVCOPIES];
  logic [WIDTH-1:0]   resStage  [0:DIVCOPIES];
  logic [WIDTH+1:0]   shifted;
  logic [WIDTH+1:0]   trial;
  logic [WIDTH-1:0]   nextOpnd;

  //////////////////////////////////////////////////////////////////////
  // Load alignment
  //////////////////////////////////////////////////////////////////////

  // Digits that will be consumed, two operand bits per root digit
  assign digits = SHW'(cycles) * SHW'(DIVCOPIES);
  assign opBits = (op == opSqrt) ? (digits << 1) : digits;

  // Skipped leading steps would only shift bits into the remainder
  // Divide by zero pushes all of a into the remainder and stops there
  assign shiftAmt = divByZero ? SHW'(WIDTH) : SHW'(WIDTH) - opBits;
  assign preShift = {{WIDTH{1'b0}}, a} << shiftAmt;

  //////////////////////////////////////////////////////////////////////
  // Restoring stages
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    prStage[0]   = remQ;
    opndStage[0] = opndQ;
    resStage[0]  = resultQ;
    for (int s = 0; s < DIVCOPIES; s++) begin
      if (opQ == opDiv) begin
        // One dividend bit in, compare against the divisor
        shifted  = {prStage[s][WIDTH:0], opndStage[s][WIDTH-1]};
        trial    = {2'b00, bQ};
        nextOpnd = {opndStage[s][WIDTH-2:0], 1'b0};
      end else begin
        // Two radicand bits in, trial is 4*root + 1
        shifted  = {prStage[s][WIDTH-1:0], opndStage[s][WIDTH-1:WIDTH-2]};
        trial    = {resStage[s], 2'b01};
        nextOpnd = {opndStage[s][WIDTH-3:0], 2'b00};
      end
      if (shifted >= trial) begin
        prStage[s+1]  = shifted - trial;
        resStage[s+1] = {resStage[s][WIDTH-2:0], 1'b1};
      end else begin
        prStage[s+1]  = shifted;
        resStage[s+1] = {resStage[s][WIDTH-2:0], 1'b0};
      end
      opndStage[s+1] = nextOpnd;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      opQ  <= opDiv;
      dbzQ <= 1'b0;
    end else if (load) begin
      opQ  <= op;
      dbzQ <= divByZero;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      bQ      <= b;
      remQ    <= {2'b00, preShift[2*WIDTH-1:WIDTH]};
      opndQ   <= preShift[WIDTH-1:0];
      resultQ <= '0;
    end else if (step && !dbzQ) begin
      remQ    <= prStage[DIVCOPIES];
      opndQ   <= opndStage[DIVCOPIES];
      resultQ <= resStage[DIVCOPIES];
    end
  end

  // Divide by zero reads all ones, remainder already holds the dividend
  assign result = dbzQ ? {WIDTH{1'b1}} : resultQ;
  assign rem    = remQ[WIDTH-1:0];

endmodule

`default_nettype wire

//--- verilog/divSqrtPkg.sv
// Shared operation and control-state types for the divide / square-root unit
`default_nettype none

package divSqrtPkg;

  //////////////////////////////////////////////////////////////////////
  // Operation select
  //////////////////////////////////////////////////////////////////////

  // Unsigned integer divide or integer square root
  typedef enum logic {
    opDiv  = 1'b0,
    opSqrt = 1'b1
  } divSqrtOpE;

  //////////////////////////////////////////////////////////////////////
  // Control FSM states
  //////////////////////////////////////////////////////////////////////

  // Idle waits for req, busy iterates, done holds ack until req drops
  typedef enum logic [1:0] {
    stIdle = 2'd0,
    stBusy = 2'd1,
    stDone = 2'd2
  } divSqrtStateE;

endpackage

`default_nettype wire

//--- verilog/divSqrtPreproc.sv
// Operand preprocessing: leading zeros, result-bit count and divide-by-zero
`default_nettype none

module divSqrtPreproc import divSqrtPkg::*; #(
  parameter int WIDTH     = 16,
  parameter int DIVCOPIES = 2
) (
  input  divSqrtOpE                      op,
  input  logic [WIDTH-1:0]               a,
  input  logic [WIDTH-1:0]               b,
  output logic [$clog2(WIDTH+1)-1:0]     resultBits,
  output logic                           divByZero
);

  // Count width, enough to hold WIDTH itself
  localparam int CNTW = $clog2(WIDTH+1);

  logic [CNTW-1:0] lzA;
  logic [CNTW-1:0] lzB;
  // One extra bit so the rounding add never wraps
  logic [CNTW:0]   sigA;
  logic [CNTW:0]   rootBits;

  // Leading-zero count, WIDTH for an all-zero operand
  function automatic logic [CNTW-1:0] lzc(input logic [WIDTH-1:0] x);
    logic            found;
    logic [CNTW-1:0] n;
    found = 1'b0;
    n     = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (!found) begin
        if (x[i]) found = 1'b1;
        else      n = n + 1'b1;
      end
    end
    return n;
  endfunction

  assign lzA = lzc(a);
  assign lzB = lzc(b);

  //////////////////////////////////////////////////////////////////////
  // Result-bit count
  //////////////////////////////////////////////////////////////////////

  // Significant bits of the radicand, then half of it rounded up
  assign sigA     = (CNTW+1)'(WIDTH) - {1'b0, lzA};
  assign rootBits = (sigA + 1'b1) >> 1;

  // Zero divisor only matters for division
  assign divByZero = (op == opDiv) && (b == '0);

  always_comb begin
    if (op == opDiv) begin
      // Quotient bits = lzB - lzA + 1, never below one
      if (divByZero) begin
        resultBits = CNTW'(1);
      end else if (lzB >= lzA) begin
        resultBits = lzB - lzA + 1'b1;
      end else begin
        // Dividend smaller than divisor, quotient is zero
        resultBits = CNTW'(1);
      end
    end else begin
      // Zero radicand still takes one digit
      if (rootBits == '0) resultBits = CNTW'(1);
      else                resultBits = rootBits[CNTW-1:0];
    end
  end

endmodule

`default_nettype wire

//--- verilog/divSqrtUnit.sv
// Top level of the iterative unsigned integer divide and square-root unit
`default_nettype none

module divSqrtUnit import divSqrtPkg::*; #(
  parameter int WIDTH     = 16,
  parameter int DIVCOPIES = 2
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             req,
  input  divSqrtOpE        op,
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic             ack,
  output logic [WIDTH-1:0] result,
  output logic [WIDTH-1:0] rem
);

  localparam int CNTW = $clog2(WIDTH+1);

  logic [CNTW-1:0] resultBits;
  logic [CNTW-1:0] cycles;
  logic            divByZero;
  logic            load;
  logic            step;

  //////////////////////////////////////////////////////////////////////
  // Combinational front end
  //////////////////////////////////////////////////////////////////////

  divSqrtPreproc #(.WIDTH(WIDTH), .DIVCOPIES(DIVCOPIES)) uPreproc (
    .op(op), .a(a), .b(b), .resultBits(resultBits), .divByZero(divByZero)
  );

  divSqrtCycles #(.WIDTH(WIDTH), .DIVCOPIES(DIVCOPIES)) uCycles (
    .resultBits(resultBits), .cycles(cycles)
  );

  //////////////////////////////////////////////////////////////////////
  // Control and datapath
  //////////////////////////////////////////////////////////////////////

  divSqrtFsm #(.WIDTH(WIDTH), .DIVCOPIES(DIVCOPIES)) uFsm (
    .clk(clk), .rstN(rstN), .req(req), .cycles(cycles),
    .ack(ack), .load(load), .step(step)
  );

  divSqrtIter #(.WIDTH(WIDTH), .DIVCOPIES(DIVCOPIES)) uIter (
    .clk(clk), .rstN(rstN), .load(load), .step(step), .op(op),
    .a(a), .b(b), .cycles(cycles), .divByZero(divByZero),
    .result(result), .rem(rem)
  );

endmodule

`default_nettype wire
